//--- src/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

`define ADDR_WIDTH    8
`define MEM_DEPTH     256
`define INST_WIDTH    32
`define DATA_WIDTH    8

// Control opcodes seen by the sequencer
`define OPC_JMP       8'h10
`define OPC_HALT      8'hFF

// APB register map
`define REG_CTRL      8'h00
`define REG_START     8'h04
`define REG_STATUS    8'h08
`define REG_COUNT     8'h0C
`define REG_MEM_ADDR  8'h10
`define REG_MEM_DATA  8'h14

`endif

//--- src/fetch_pkg.sv
`default_nettype none
`include "fetch_macros.svh"

package fetch_pkg;

   typedef struct packed {
      logic [7:0]  opcode;
      logic [3:0]  rd;
      logic [3:0]  rs;
      logic [15:0] imm;                          // Jump target in the low bits
   } inst_fields_t;

   // One instruction word read either as fetched bytes or as fields
   typedef union packed {
      logic [0:`INST_WIDTH/`DATA_WIDTH-1][`DATA_WIDTH-1:0] bytes;  // Element 0 is the MSB
      inst_fields_t                                        fields;
   } inst_t;

   typedef enum logic {
      IDLE,
      FETCH
   } fetch_state_t;

endpackage

`default_nettype wire

//--- src/inst_mem.sv
`default_nettype none
`include "fetch_macros.svh"

module inst_mem (
   input  logic                   clk,
   input  logic                   we,
   input  logic [`ADDR_WIDTH-1:0] waddr,
   input  logic [`ADDR_WIDTH-1:0] raddr,
   input  logic [`DATA_WIDTH-1:0] wdata,
   output logic [`DATA_WIDTH-1:0] rdata
);

   logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

   // Loaded from the register block one byte at a time
   always_ff @(posedge clk) begin
      if (we)
         mem[waddr] <= wdata;
   end

   assign rdata = mem[raddr];                    // Same cycle read for the fetch unit

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`default_nettype none
`include "fetch_macros.svh"

module fetch_unit (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   fetch_go,
   input  logic [`ADDR_WIDTH-1:0] pc,
   input  logic [`DATA_WIDTH-1:0] mem_rdata,
   output logic [`ADDR_WIDTH-1:0] mem_raddr,
   output fetch_pkg::inst_t       inst,
   output logic                   inst_ready
);

   import fetch_pkg::*;

   fetch_state_t state;
   logic [1:0]   idx;

   // Index is zero while idle so the first byte is read in the fetch_go cycle
   assign mem_raddr = pc + {{(`ADDR_WIDTH-2){1'b0}}, idx};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= IDLE;
         idx        <= 2'd0;
         inst       <= '0;
         inst_ready <= 1'b0;
      end else begin
         inst_ready <= 1'b0;
         case (state)
            IDLE: begin
               if (fetch_go) begin
                  inst          <= '0;           // Unread bytes show as zero
                  inst.bytes[0] <= mem_rdata;
                  idx           <= 2'd1;
                  state         <= FETCH;
               end
            end
            FETCH: begin
               inst.bytes[idx] <= mem_rdata;
               idx             <= idx + 2'd1;    // Back to zero after the last byte
               if (idx == 2'd3) begin
                  inst_ready <= 1'b1;
                  state      <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
               idx   <= 2'd0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/pc_sequencer.sv
`default_nettype none
`include "fetch_macros.svh"

module pc_sequencer (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   run,
   input  logic [`ADDR_WIDTH-1:0] start_pc,
   input  fetch_pkg::inst_t       inst,
   input  logic                   inst_ready,
   output logic [`ADDR_WIDTH-1:0] pc,
   output logic                   fetch_go,
   output logic                   inst_valid,
   output logic [`ADDR_WIDTH-1:0] inst_pc,
   output logic                   busy,
   output logic                   halted
);

   localparam logic [`ADDR_WIDTH-1:0] PC_STEP = `INST_WIDTH / `DATA_WIDTH;

   logic                   run_q;
   logic                   start;
   logic                   is_jmp;
   logic                   is_halt;
   logic [`ADDR_WIDTH-1:0] next_pc;

   assign is_jmp  = inst.fields.opcode == `OPC_JMP;
   assign is_halt = inst.fields.opcode == `OPC_HALT;
   assign next_pc = is_jmp ? inst.fields.imm[`ADDR_WIDTH-1:0] : pc + PC_STEP;
   assign start   = run & ~run_q & ~busy;        // Rising run while idle

   assign inst_valid = inst_ready & busy & ~is_halt;  // Halt words are not published
   assign inst_pc    = pc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run_q    <= 1'b0;
         pc       <= '0;
         fetch_go <= 1'b0;
         busy     <= 1'b0;
         halted   <= 1'b0;
      end else begin
         run_q    <= run;
         fetch_go <= 1'b0;
         if (start) begin
            pc       <= start_pc;
            fetch_go <= 1'b1;
            busy     <= 1'b1;
            halted   <= 1'b0;
         end else if (inst_ready && busy) begin
            if (is_halt) begin
               busy   <= 1'b0;
               halted <= 1'b1;
            end else begin
               pc <= next_pc;
               if (run)
                  fetch_go <= 1'b1;
               else
                  busy <= 1'b0;                  // Stopped at the boundary
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- src/fetch_regs.sv
`default_nettype none
`include "fetch_macros.svh"

module fetch_regs (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [7:0]             paddr,
   input  logic [31:0]            pwdata,
   output logic [31:0]            prdata,
   output logic                   pready,
   output logic                   pslverr,
   input  logic                   inst_valid,
   input  logic                   busy,
   input  logic                   halted,
   output logic                   run,
   output logic [`ADDR_WIDTH-1:0] start_pc,
   output logic                   mem_we,
   output logic [`ADDR_WIDTH-1:0] mem_waddr,
   output logic [`DATA_WIDTH-1:0] mem_wdata
);

   logic        access;
   logic        wr_en;
   logic        mapped;
   logic        locked;
   logic        wr_ok;
   logic        run_start;
   logic        busy_q;
   logic [31:0] count;

   assign access = psel & penable;
   assign wr_en  = access & pwrite;

   always_comb begin
      case (paddr)
         `REG_CTRL, `REG_START, `REG_STATUS,
         `REG_COUNT, `REG_MEM_ADDR, `REG_MEM_DATA: mapped = 1'b1;
         default:                                  mapped = 1'b0;
      endcase
   end

   assign locked  = busy & ((paddr == `REG_START) | (paddr == `REG_MEM_DATA));
   assign wr_ok   = wr_en & mapped & ~locked;
   assign pslverr = access & (~mapped | (pwrite & locked));
   assign pready  = 1'b1;                        // No wait states

   // Memory load port with a pointer that advances after every byte
   assign mem_we    = wr_ok & (paddr == `REG_MEM_DATA);
   assign mem_wdata = pwdata[`DATA_WIDTH-1:0];

   assign run_start = wr_ok & (paddr == `REG_CTRL) & pwdata[0] & ~run & ~busy;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run       <= 1'b0;
         start_pc  <= '0;
         mem_waddr <= '0;
         busy_q    <= 1'b0;
      end else begin
         busy_q <= busy;
         if (busy_q && !busy)
            run <= 1'b0;                         // Run self-clears once the sequencer idles
         if (wr_ok) begin
            case (paddr)
               `REG_CTRL:     run       <= pwdata[0];
               `REG_START:    start_pc  <= pwdata[`ADDR_WIDTH-1:0];
               `REG_MEM_ADDR: mem_waddr <= pwdata[`ADDR_WIDTH-1:0];
               `REG_MEM_DATA: mem_waddr <= mem_waddr + 1;  // Wraps at the top of memory
               default:       ;
            endcase
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         count <= '0;
      else if (run_start)
         count <= '0;
      else if (inst_valid)
         count <= count + 1;
   end

   always_comb begin
      prdata = '0;
      if (psel && !pwrite) begin
         case (paddr)
            `REG_CTRL:     prdata[0]               = run;
            `REG_START:    prdata[`ADDR_WIDTH-1:0] = start_pc;
            `REG_STATUS:   prdata[1:0]             = {halted, busy};
            `REG_COUNT:    prdata                  = count;
            `REG_MEM_ADDR: prdata[`ADDR_WIDTH-1:0] = mem_waddr;
            default:       prdata                  = '0;  // Data port reads as zero
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/fetch_top.sv
`default_nettype none
`include "fetch_macros.svh"

module fetch_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [7:0]             paddr,
   input  logic [31:0]            pwdata,
   output logic [31:0]            prdata,
   output logic                   pready,
   output logic                   pslverr,
   output fetch_pkg::inst_t       inst,
   output logic [`ADDR_WIDTH-1:0] inst_pc,
   output logic                   inst_valid
);

   logic                   run;
   logic [`ADDR_WIDTH-1:0] start_pc;
   logic                   busy;
   logic                   halted;
   logic                   mem_we;
   logic [`ADDR_WIDTH-1:0] mem_waddr;
   logic [`DATA_WIDTH-1:0] mem_wdata;
   logic [`ADDR_WIDTH-1:0] mem_raddr;
   logic [`DATA_WIDTH-1:0] mem_rdata;
   logic [`ADDR_WIDTH-1:0] pc;
   logic                   fetch_go;
   logic                   inst_ready;

   fetch_regs u_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .inst_valid (inst_valid),
      .busy       (busy),
      .halted     (halted),
      .run        (run),
      .start_pc   (start_pc),
      .mem_we     (mem_we),
      .mem_waddr  (mem_waddr),
      .mem_wdata  (mem_wdata)
   );

   inst_mem u_mem (
      .clk   (clk),
      .we    (mem_we),
      .waddr (mem_waddr),
      .raddr (mem_raddr),
      .wdata (mem_wdata),
      .rdata (mem_rdata)
   );

   fetch_unit u_fetch (
      .clk        (clk),
      .rst_n      (rst_n),
      .fetch_go   (fetch_go),
      .pc         (pc),
      .mem_rdata  (mem_rdata),
      .mem_raddr  (mem_raddr),
      .inst       (inst),
      .inst_ready (inst_ready)
   );

   pc_sequencer u_seq (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .start_pc   (start_pc),
      .inst       (inst),
      .inst_ready (inst_ready),
      .pc         (pc),
      .fetch_go   (fetch_go),
      .inst_valid (inst_valid),
      .inst_pc    (inst_pc),
      .busy       (busy),
      .halted     (halted)
   );

endmodule

`default_nettype wire

//--- verification/fetch_tb.sv
`default_nettype none
`include "fetch_macros.svh"

module fetch_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import fetch_pkg::*;

   localparam int MAX_REC  = 64;
   localparam int REC_TIME = 60;                 // Cycles allowed per vector line

   logic                   clk;
   logic                   rst_n;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [7:0]             paddr;
   logic [31:0]            pwdata;
   logic [31:0]            prdata;
   logic                   pready;
   logic                   pslverr;
   inst_t                  inst;
   logic [`ADDR_WIDTH-1:0] inst_pc;
   logic                   inst_valid;

   logic [31:0]            vec [4*MAX_REC];      // Four words per vector line
   logic [31:0]            exp_word_q [$];
   logic [`ADDR_WIDTH-1:0] exp_pc_q [$];
   int                     n_rec;
   int                     err_count;
   int                     test_mark;            // Error count when the current test began
   int                     pass_n;
   int                     fail_n;

   fetch_top dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .inst       (inst),
      .inst_pc    (inst_pc),
      .inst_valid (inst_valid)
   );

   always #20 clk = ~clk;

   task automatic check_inst(input inst_t exp, input inst_t act);
      if (act !== exp) begin
         $display("ERR inst: expected %h, got %h", exp, act);
         err_count++;
      end
   endtask

   task automatic check_pc(input logic [`ADDR_WIDTH-1:0] exp, input logic [`ADDR_WIDTH-1:0] act);
      if (act !== exp) begin
         $display("ERR inst_pc: expected %h, got %h", exp, act);
         err_count++;
      end
   endtask

   task automatic check_word(input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("ERR prdata at %h: expected %h, got %h", paddr, exp, act);
         err_count++;
      end
   endtask

   task automatic check_err(input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR pslverr at %h: expected %h, got %h", paddr, exp, act);
         err_count++;
      end
   endtask

   task automatic check_ready(input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR pready at %h: expected %h, got %h", paddr, exp, act);
         err_count++;
      end
   endtask

   // Setup and access phase of one APB transfer with the outputs sampled during access
   task automatic transfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      #1;
      rdata = prdata;
      err   = pslverr;
      check_ready(1'b1, pready);                 // No wait states on any access
      @(posedge clk);
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
      logic [31:0] rdata;
      logic        err;
      transfer(1'b1, addr, data, rdata, err);
      check_err(exp_err, err);
   endtask

   task automatic load_word(input logic [7:0] addr, input logic [31:0] word);
      write_reg(`REG_MEM_ADDR, {24'h0, addr}, 1'b0);
      for (int b = 3; b >= 0; b--)
         write_reg(`REG_MEM_DATA, {24'h0, word[8*b +: 8]}, 1'b0);  // MSB first
   endtask

   task automatic wait_idle();
      logic [31:0] status;
      logic        err;
      status = 32'h1;
      while (status[0])
         transfer(1'b0, `REG_STATUS, 32'h0, status, err);
   endtask

   task automatic close_test(input int num);
      if (exp_word_q.size() != 0) begin
         $display("test %0d: %0d expected instructions never appeared", num, exp_word_q.size());
         err_count++;
         exp_word_q.delete();
         exp_pc_q.delete();
      end
      if (err_count == test_mark) begin
         pass_n++;
         $display("test %0d passed", num);
      end else begin
         fail_n++;
         $display("test %0d failed with %0d errors", num, err_count - test_mark);
      end
      test_mark = err_count;
   endtask

   task automatic run_command(input int r, input logic [31:0] cmd, input logic [31:0] a,
                              input logic [31:0] d, input logic [31:0] e);
      logic [31:0] rdata;
      logic        err;
      case (cmd)
         32'h1: write_reg(a[7:0], d, e[0]);
         32'h2: begin
            transfer(1'b0, a[7:0], 32'h0, rdata, err);
            check_word(d, rdata);
            check_err(e[0], err);
         end
         32'h3: begin
            exp_pc_q.push_back(a[`ADDR_WIDTH-1:0]);
            exp_word_q.push_back(d);
         end
         32'h4: wait_idle();
         32'h5: load_word(a[7:0], d);
         32'h6: close_test(int'(a));
         default: begin
            $display("unknown command %h in vector line %0d", cmd, r);
            err_count++;
         end
      endcase
   endtask

   // Each published instruction must be the next one expected
   task automatic match_stream();
      inst_t exp_inst;
      if (exp_word_q.size() == 0) begin
         $display("unexpected instruction %h at pc %h", inst, inst_pc);
         err_count++;
      end else begin
         exp_inst = exp_word_q.pop_front();
         check_inst(exp_inst, inst);
         check_pc(exp_pc_q.pop_front(), inst_pc);
      end
   endtask

   always @(negedge clk) begin
      if (rst_n && inst_valid)
         match_stream();
   end

   initial begin
      wait (n_rec > 0);
      repeat (n_rec * REC_TIME + 20) @(posedge clk);
      $display("timeout: vectors did not finish within %0d cycles", n_rec * REC_TIME + 20);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = 8'h0;
      pwdata    = 32'h0;
      err_count = 0;
      test_mark = 0;
      pass_n    = 0;
      fail_n    = 0;
      $readmemh("verification/fetch_vectors.txt", vec);
      n_rec = 0;
      while (n_rec < MAX_REC && !$isunknown(vec[4*n_rec]) && vec[4*n_rec] != 32'h0)
         n_rec++;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int r = 0; r < n_rec; r++)
         run_command(r, vec[4*r], vec[4*r+1], vec[4*r+2], vec[4*r+3]);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      $display("tests passed: %0d, failed: %0d, errors: %0d", pass_n, fail_n, err_count);
      if (err_count == 0 && fail_n == 0 && pass_n > 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/fetch_vectors.txt
// Columns: command, address, data, expected pslverr (hex)
// Commands: 1 write, 2 read, 3 expect pc and word, 4 wait idle, 5 load word, 6 end of test
2 00 00000000 0
2 08 00000000 0
2 0C 00000000 0
6 01 00000000 0
5 00 01234567 0
5 04 FF000000 0
5 08 100000FC 0
5 F8 2011ABCD 0
5 FC 30225A5A 0
1 04 00000000 0
3 00 01234567 0
1 00 00000001 0
4 00 00000000 0
2 08 00000002 0
2 0C 00000001 0
6 02 00000000 0
1 04 000000F8 0
3 F8 2011ABCD 0
3 FC 30225A5A 0
3 00 01234567 0
1 00 00000001 0
4 00 00000000 0
2 0C 00000003 0
6 03 00000000 0
1 04 00000008 0
3 08 100000FC 0
3 FC 30225A5A 0
3 00 01234567 0
1 00 00000001 0
1 10 00000000 0
1 14 000000EE 1
1 18 00000055 1
2 18 00000000 1
4 00 00000000 0
2 08 00000002 0
6 04 00000000 0
1 04 000000FC 0
3 FC 30225A5A 0
3 00 01234567 0
1 00 00000001 0
2 08 00000001 0
2 08 00000001 0
2 08 00000001 0
1 00 00000000 0
4 00 00000000 0
2 0C 00000002 0
2 08 00000000 0
6 05 00000000 0
0 00 00000000 0

//--- project.f
+incdir+src
src/fetch_pkg.sv
src/inst_mem.sv
src/fetch_unit.sv
src/pc_sequencer.sv
src/fetch_regs.sv
src/fetch_top.sv
verification/fetch_tb.sv

//--- Makefile
TOP := fetch_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

obj_dir/V$(TOP): project.f $(wildcard src/*.sv src/*.svh verification/*.sv)
	verilator --binary --timing -j 0 --top-module $(TOP) -f project.f

lint:
	verilator --lint-only --timing --top-module fetch_top -f project.f

clean:
	rm -rf obj_dir $(LOG)
